// File: tetrisVga_params.svh
`ifndef TETRIS_VGA_PARAMS_SVH
`define TETRIS_VGA_PARAMS_SVH

// 640x480 at 60 Hz, counted in pixel clocks and lines.
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48
`define H_TOTAL 800

`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33
`define V_TOTAL 525

// The board sits right of centre, 10 cells wide and 20 cells tall.
`define BOARD_LEFT 400
`define BOARD_TOP 40
`define CELL_SIZE 20
`define BOARD_COLS 10
`define BOARD_ROWS 20
`define BOARD_CELLS 200

// Palette entries are blue, green, red from the top byte down.
`define COLOR_FILLED 24'hFF8020
`define COLOR_EMPTY 24'h202020
`define COLOR_WALL 24'h909090

`endif

// File: tetrisVgaPkg.sv
package tetrisVgaPkg;

	// Horizontal or vertical position, wide enough for the full 800x525 raster.
	typedef logic [9:0] pixelCoord_t;

	// Cell index, row times 10 plus column.
	typedef logic [7:0] boardAddr_t;

	typedef enum logic [1:0]
	{
		classOutside = 2'd0,
		classWall = 2'd1,
		classBoard = 2'd2
	} cellClass_t;

	// Both sync pulses are active low.
	typedef struct packed
	{
		logic hSync;
		logic vSync;
		logic blankN;
	} syncBundle_t;

	typedef struct packed
	{
		logic [7:0] blue;
		logic [7:0] green;
		logic [7:0] red;
	} pixelColor_t;

endpackage

// File: rasterTiming.sv
`timescale 1ns/10ps
`include "tetrisVga_params.svh"

module rasterTiming (
	input logic VGA_CLK_n,
	input logic iRST_n,
	output tetrisVgaPkg::pixelCoord_t pixelX,
	output tetrisVgaPkg::pixelCoord_t pixelY,
	output tetrisVgaPkg::syncBundle_t sync
);

	localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
	localparam int H_SYNC_END = H_SYNC_START + `H_SYNC;
	localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
	localparam int V_SYNC_END = V_SYNC_START + `V_SYNC;

	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (pixelX == tetrisVgaPkg::pixelCoord_t'(`H_TOTAL - 1));
	assign frameEnd = (pixelY == tetrisVgaPkg::pixelCoord_t'(`V_TOTAL - 1));

	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			pixelX <= '0;
			pixelY <= '0;
		end
		else if (lineEnd)
		begin
			pixelX <= '0;
			if (frameEnd)
				pixelY <= '0;
			else
				pixelY <= pixelY + 1'b1; // The line counter steps once per wrap.
		end
		else
		begin
			pixelX <= pixelX + 1'b1;
		end
	end

	// Decoded straight from the counters, the delay line downstream registers them.
	always_comb
	begin
		sync.hSync = !((pixelX >= H_SYNC_START) && (pixelX < H_SYNC_END));
		sync.vSync = !((pixelY >= V_SYNC_START) && (pixelY < V_SYNC_END));
		sync.blankN = (pixelX < `H_ACTIVE) && (pixelY < `V_ACTIVE);
	end

endmodule

// File: cellLocator.sv
`timescale 1ns/10ps
`include "tetrisVga_params.svh"

module cellLocator (
	input logic VGA_CLK_n,
	input logic iRST_n,
	input tetrisVgaPkg::pixelCoord_t pixelX,
	input tetrisVgaPkg::pixelCoord_t pixelY,
	output tetrisVgaPkg::boardAddr_t cellAddr,
	output tetrisVgaPkg::cellClass_t cellClass
);

	localparam int BOARD_RIGHT = `BOARD_LEFT + `BOARD_COLS * `CELL_SIZE;
	localparam int BOARD_BOTTOM = `BOARD_TOP + `BOARD_ROWS * `CELL_SIZE;

	logic inBoard;
	tetrisVgaPkg::pixelCoord_t offsetX;
	tetrisVgaPkg::pixelCoord_t offsetY;
	logic [3:0] cellCol;
	logic [4:0] cellRow;
	logic isWall;
	tetrisVgaPkg::boardAddr_t nextAddr;

	assign inBoard = (pixelX >= `BOARD_LEFT) && (pixelX < BOARD_RIGHT) &&
		(pixelY >= `BOARD_TOP) && (pixelY < BOARD_BOTTOM);

	assign offsetX = pixelX - tetrisVgaPkg::pixelCoord_t'(`BOARD_LEFT);
	assign offsetY = pixelY - tetrisVgaPkg::pixelCoord_t'(`BOARD_TOP);

	// Only meaningful inside the board, where the quotients stay in range.
	assign cellCol = 4'(offsetX / tetrisVgaPkg::pixelCoord_t'(`CELL_SIZE));
	assign cellRow = 5'(offsetY / tetrisVgaPkg::pixelCoord_t'(`CELL_SIZE));

	// Side walls and the floor row.
	assign isWall = (cellCol == 4'd0) || (cellCol == 4'(`BOARD_COLS - 1)) ||
		(cellRow == 5'(`BOARD_ROWS - 1));

	assign nextAddr = 8'(cellRow * `BOARD_COLS) + 8'(cellCol);

	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			cellAddr <= '0;
			cellClass <= tetrisVgaPkg::classOutside;
		end
		else if (!inBoard)
		begin
			cellAddr <= '0; // Keeps the read address valid off the board.
			cellClass <= tetrisVgaPkg::classOutside;
		end
		else
		begin
			cellAddr <= nextAddr;
			cellClass <= isWall ? tetrisVgaPkg::classWall : tetrisVgaPkg::classBoard;
		end
	end

endmodule

// File: boardStore.sv
`timescale 1ns/10ps
`include "tetrisVga_params.svh"

module boardStore (
	input logic VGA_CLK_n,
	input logic iRST_n,
	input tetrisVgaPkg::boardAddr_t rdAddr,
	output logic rdBit,
	input logic wrEn,
	input tetrisVgaPkg::boardAddr_t wrAddr,
	input logic wrBit
);

	logic [`BOARD_CELLS-1:0] cells;

	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			cells <= '0; // The board starts empty.
			rdBit <= 1'b0;
		end
		else
		begin
			if (wrEn && (wrAddr < `BOARD_CELLS))
				cells[wrAddr] <= wrBit;
			if (rdAddr < `BOARD_CELLS)
				rdBit <= cells[rdAddr];
			else
				rdBit <= 1'b0;
		end
	end

endmodule

// File: pipeDelay.sv
`timescale 1ns/10ps

module pipeDelay #(
	parameter type payload_t = logic,
	parameter int DEPTH = 1,
	parameter int TAP_DEPTH = DEPTH,
	parameter payload_t RESET_VALUE = payload_t'(0)
) (
	input logic VGA_CLK_n,
	input logic iRST_n,
	input payload_t din,
	output payload_t dout,
	output payload_t tap
);

	payload_t stages [DEPTH];

	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
		begin
			for (int i = 0; i < DEPTH; i++)
				stages[i] <= RESET_VALUE;
		end
		else
		begin
			stages[0] <= din;
			for (int i = 1; i < DEPTH; i++)
				stages[i] <= stages[i-1];
		end
	end

	assign dout = stages[DEPTH-1];
	assign tap = stages[TAP_DEPTH-1]; // Intermediate stage for logic that sits mid-pipe.

endmodule

// File: colorSelect.sv
`timescale 1ns/10ps
`include "tetrisVga_params.svh"

module colorSelect (
	input logic VGA_CLK_n,
	input logic iRST_n,
	input tetrisVgaPkg::cellClass_t cellClass,
	input logic boardBit,
	input logic blankN,
	output tetrisVgaPkg::pixelColor_t color
);

	tetrisVgaPkg::pixelColor_t nextColor;

	always_comb
	begin
		case (cellClass)
			tetrisVgaPkg::classWall:
				nextColor = tetrisVgaPkg::pixelColor_t'(`COLOR_WALL);
			tetrisVgaPkg::classBoard:
				nextColor = boardBit ? tetrisVgaPkg::pixelColor_t'(`COLOR_FILLED)
					: tetrisVgaPkg::pixelColor_t'(`COLOR_EMPTY);
			default:
				nextColor = tetrisVgaPkg::pixelColor_t'(`COLOR_EMPTY); // Background.
		endcase
		if (!blankN)
			nextColor = '0; // Porches and sync must be black.
	end

	always_ff @(posedge VGA_CLK_n or negedge iRST_n)
	begin
		if (!iRST_n)
			color <= '0;
		else
			color <= nextColor;
	end

endmodule

// File: tetrisVgaTop.sv
`timescale 1ns/10ps

module tetrisVgaTop (
	input logic VGA_CLK_n,
	input logic iRST_n,
	input logic boardWrEn,
	input tetrisVgaPkg::boardAddr_t boardWrAddr,
	input logic boardWrData,
	output logic oHS,
	output logic oVS,
	output logic oBLANK_n,
	output logic [7:0] blue,
	output logic [7:0] green,
	output logic [7:0] red
);

	localparam tetrisVgaPkg::syncBundle_t SYNC_IDLE = '{hSync: 1'b1, vSync: 1'b1, blankN: 1'b0};

	tetrisVgaPkg::pixelCoord_t pixelX;
	tetrisVgaPkg::pixelCoord_t pixelY;
	tetrisVgaPkg::syncBundle_t rawSync;
	tetrisVgaPkg::syncBundle_t midSync;
	tetrisVgaPkg::syncBundle_t outSync;
	tetrisVgaPkg::boardAddr_t cellAddr;
	tetrisVgaPkg::cellClass_t cellClass;
	tetrisVgaPkg::cellClass_t cellClassDly;
	logic boardBit;
	tetrisVgaPkg::pixelColor_t color;

	rasterTiming rasterTiming_inst (
		.VGA_CLK_n(VGA_CLK_n),
		.iRST_n(iRST_n),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.sync(rawSync)
	);

	cellLocator cellLocator_inst (
		.VGA_CLK_n(VGA_CLK_n),
		.iRST_n(iRST_n),
		.pixelX(pixelX),
		.pixelY(pixelY),
		.cellAddr(cellAddr),
		.cellClass(cellClass)
	);

	boardStore boardStore_inst (
		.VGA_CLK_n(VGA_CLK_n),
		.iRST_n(iRST_n),
		.rdAddr(cellAddr),
		.rdBit(boardBit),
		.wrEn(boardWrEn),
		.wrAddr(boardWrAddr),
		.wrBit(boardWrData)
	);

	// Matches the class to the board bit read one cycle later.
	pipeDelay #(
		.payload_t(tetrisVgaPkg::cellClass_t),
		.DEPTH(1),
		.RESET_VALUE(tetrisVgaPkg::classOutside)
	) classDelay_inst (
		.VGA_CLK_n(VGA_CLK_n),
		.iRST_n(iRST_n),
		.din(cellClass),
		.dout(cellClassDly),
		.tap()
	);

	// Sync follows the three registered stages of the colour path.
	pipeDelay #(
		.payload_t(tetrisVgaPkg::syncBundle_t),
		.DEPTH(3),
		.TAP_DEPTH(2),
		.RESET_VALUE(SYNC_IDLE)
	) syncDelay_inst (
		.VGA_CLK_n(VGA_CLK_n),
		.iRST_n(iRST_n),
		.din(rawSync),
		.dout(outSync),
		.tap(midSync)
	);

	colorSelect colorSelect_inst (
		.VGA_CLK_n(VGA_CLK_n),
		.iRST_n(iRST_n),
		.cellClass(cellClassDly),
		.boardBit(boardBit),
		.blankN(midSync.blankN),
		.color(color)
	);

	assign oHS = outSync.hSync;
	assign oVS = outSync.vSync;
	assign oBLANK_n = outSync.blankN;
	assign blue = color.blue;
	assign green = color.green;
	assign red = color.red;

endmodule

// File: tetrisVgaTb.sv
`timescale 1ns/10ps
`include "tetrisVga_params.svh"

module tetrisVgaTb;

	localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
	localparam int TIMEOUT_CYCLES = 8 * FRAME_CYCLES; // About seven frames of tests plus margin.

	logic VGA_CLK_n;
	logic iRST_n;
	logic boardWrEn;
	tetrisVgaPkg::boardAddr_t boardWrAddr;
	logic boardWrData;
	logic oHS;
	logic oVS;
	logic oBLANK_n;
	logic [7:0] blue;
	logic [7:0] green;
	logic [7:0] red;
	logic [`BOARD_CELLS-1:0] boardModel;
	tetrisVgaPkg::pixelColor_t seenColor [`BOARD_CELLS];
	logic [31:0] rngState;
	int errors = 0;
	int checks = 0;
	int testsRun = 0;
	int cycleCount = 0;

	tetrisVgaTop tetrisVgaTop_inst (
		.VGA_CLK_n(VGA_CLK_n),
		.iRST_n(iRST_n),
		.boardWrEn(boardWrEn),
		.boardWrAddr(boardWrAddr),
		.boardWrData(boardWrData),
		.oHS(oHS),
		.oVS(oVS),
		.oBLANK_n(oBLANK_n),
		.blue(blue),
		.green(green),
		.red(red)
	);

	initial
	begin
		VGA_CLK_n = 1'b0;
		forever #5 VGA_CLK_n = ~VGA_CLK_n;
	end

	always @(posedge VGA_CLK_n)
	begin
		cycleCount++;
		if (cycleCount >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the tests did not finish within %0d cycles.", TIMEOUT_CYCLES);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// Colour a pixel should show, from the board rules and the model.
	function automatic tetrisVgaPkg::pixelColor_t expectedColor(input int x, input int y);
		int col;
		int row;
		if (x < 400 || x >= 600 || y < 40 || y >= 440)
			return tetrisVgaPkg::pixelColor_t'(`COLOR_EMPTY);
		col = (x - 400) / 20;
		row = (y - 40) / 20;
		if (col == 0 || col == 9 || row == 19)
			return tetrisVgaPkg::pixelColor_t'(`COLOR_WALL);
		return boardModel[row * 10 + col] ? tetrisVgaPkg::pixelColor_t'(`COLOR_FILLED)
			: tetrisVgaPkg::pixelColor_t'(`COLOR_EMPTY);
	endfunction

	task automatic compareColor(input string name, input tetrisVgaPkg::pixelColor_t expected,
		input tetrisVgaPkg::pixelColor_t actual);
		checks++;
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic compareCount(input string name, input int expected, input int actual);
		checks++;
		if (actual !== expected)
		begin
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
			errors++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testsRun++;
		$display("%s: %s, %0d errors", name, (errors == errorsBefore) ? "ok" : "failed",
			errors - errorsBefore);
	endtask

	// Returns on the sample where oVS has just gone low.
	task automatic waitFrameStart();
		while (!oVS)
			@(negedge VGA_CLK_n);
		while (oVS)
			@(negedge VGA_CLK_n);
	endtask

	task automatic writeCell(input int addr, input logic value);
		@(negedge VGA_CLK_n);
		boardWrEn = 1'b1;
		boardWrAddr = tetrisVgaPkg::boardAddr_t'(addr);
		boardWrData = value;
		if (addr < `BOARD_CELLS)
			boardModel[addr] = value;
	endtask

	task automatic checkIdle(input string name);
		compareCount({name, " oHS"}, 1, int'(oHS));
		compareCount({name, " oVS"}, 1, int'(oVS));
		compareCount({name, " oBLANK_n"}, 0, int'(oBLANK_n));
		compareColor({name, " colour"}, '0, tetrisVgaPkg::pixelColor_t'({blue, green, red}));
	endtask

	// Walks the next frame's active area and checks each cell centre.
	task automatic scanFrame(input string name, input bit withBackground);
		int col = 0;
		int line = 0;
		bit prevBlank = 1'b0;
		bit centre;
		tetrisVgaPkg::pixelColor_t seen;
		waitFrameStart();
		while (line < `V_ACTIVE)
		begin
			@(negedge VGA_CLK_n);
			seen = tetrisVgaPkg::pixelColor_t'({blue, green, red});
			if (oBLANK_n)
			begin
				centre = col >= 400 && col < 600 && line >= 40 && line < 440 &&
					(col - 400) % 20 == 10 && (line - 40) % 20 == 10;
				if (centre)
					seenColor[((line - 40) / 20) * 10 + (col - 400) / 20] = seen;
				if (centre || (withBackground && ((col == 0 && line == 0) ||
					(col == 399 && line == 40))))
					compareColor($sformatf("%s (%0d,%0d)", name, col, line),
						expectedColor(col, line), seen);
				col++;
			end
			else if (prevBlank)
			begin
				col = 0;
				line++;
			end
			prevBlank = oBLANK_n;
		end
	endtask

	task automatic testReset();
		repeat (16) @(negedge VGA_CLK_n);
		checkIdle("reset held");
		iRST_n = 1'b1;
		@(negedge VGA_CLK_n);
		checkIdle("reset released");
	endtask

	task automatic testSyncTiming();
		int hsLow = 0;
		int vsLow = 0;
		int blankHigh = 0;
		int activeLines = 0;
		int badPulses = 0;
		int litBlank = 0;
		int run = 0;
		bit prevBlank = 1'b0;
		waitFrameStart();
		for (int i = 0; i < FRAME_CYCLES; i++)
		begin
			if (i > 0)
				@(negedge VGA_CLK_n);
			if (!oHS)
				run++;
			else if (run != 0)
			begin
				badPulses += (run != `H_SYNC);
				run = 0;
			end
			if (!oBLANK_n && ({blue, green, red} !== 24'h0))
				litBlank++; // Porches and sync pulses must stay black.
			hsLow += !oHS;
			vsLow += !oVS;
			blankHigh += oBLANK_n;
			activeLines += prevBlank && !oBLANK_n;
			prevBlank = oBLANK_n;
		end
		compareCount("sync timing hsync low cycles", `H_SYNC * `V_TOTAL, hsLow);
		compareCount("sync timing hsync pulses of wrong width", 0, badPulses);
		compareCount("sync timing vsync low cycles", `V_SYNC * `H_TOTAL, vsLow);
		compareCount("sync timing active cycles", `H_ACTIVE * `V_ACTIVE, blankHigh);
		compareCount("sync timing active lines", `V_ACTIVE, activeLines);
		compareCount("sync timing coloured blank cycles", 0, litBlank);
	endtask

	task automatic testRandomFill();
		waitFrameStart();
		for (int a = 0; a < `BOARD_CELLS; a++)
		begin
			rngState = xorshift(rngState);
			writeCell(a, rngState[31]);
		end
		@(negedge VGA_CLK_n) boardWrEn = 1'b0;
		scanFrame("random fill", 1'b0);
	endtask

	task automatic testOverwrite();
		tetrisVgaPkg::pixelColor_t baseline [`BOARD_CELLS];
		int target = -1;
		int changed = 0;
		baseline = seenColor;
		for (int a = 0; a < `BOARD_CELLS; a++)
			if (target < 0 && boardModel[a] && a % 10 > 0 && a % 10 < 9 && a / 10 < 19)
				target = a;
		if (target < 0)
		begin
			$display("Overwrite test found no filled interior cell to clear.");
			errors++;
		end
		else
		begin
			waitFrameStart();
			writeCell(target, 1'b0);
			writeCell(250, 1'b1); // Out of range, so the board must not change.
			@(negedge VGA_CLK_n) boardWrEn = 1'b0;
			scanFrame("overwrite and range", 1'b0);
			for (int a = 0; a < `BOARD_CELLS; a++)
				changed += (seenColor[a] !== baseline[a]);
			compareCount("overwrite and range changed cells", 1, changed);
		end
	endtask

	initial
	begin
		int mark;
		iRST_n = 1'b0;
		boardWrEn = 1'b0;
		boardWrAddr = '0;
		boardWrData = 1'b0;
		boardModel = '0;
		rngState = 32'h27bade22;
		mark = errors;
		testReset();
		reportTest("reset", mark);
		mark = errors;
		testSyncTiming();
		reportTest("sync timing", mark);
		mark = errors;
		scanFrame("empty board", 1'b1);
		reportTest("empty board", mark);
		mark = errors;
		testRandomFill();
		reportTest("random fill", mark);
		mark = errors;
		testOverwrite();
		reportTest("overwrite and range", mark);
		$display("Tests run: %0d, checks: %0d, errors: %0d", testsRun, checks, errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: list.f
+incdir+.
tetrisVgaPkg.sv
rasterTiming.sv
cellLocator.sv
boardStore.sv
pipeDelay.sv
colorSelect.sv
tetrisVgaTop.sv
tetrisVgaTb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the failure line in the log.
verilator --binary --timing -Wno-fatal --top-module tetrisVgaTb -f list.f \
	-o simTetrisVga > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/simTetrisVga > sim.log 2>&1 || { echo "Simulator exited with an error"; exit 1; }
grep -q "STATUS: FAIL" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
echo "Simulation finished without failures"
